//--- src/sched_pkg.sv
`default_nettype none

package sched_pkg;

    //////////////////////////////////////////////////////////////////////
    // Field widths and bank layout.
    localparam int IDX_W           = 6;
    localparam int ROW_W           = 16;
    localparam int COL_W           = 10;
    localparam int DATA_W          = 16;

    localparam int NUM_GROUPS      = 4;
    localparam int BANKS_PER_GROUP = 4;
    localparam int NUM_BANKS       = NUM_GROUPS * BANKS_PER_GROUP;
    localparam int BG_W            = $clog2(NUM_GROUPS);
    localparam int BA_W            = $clog2(BANKS_PER_GROUP);

    //////////////////////////////////////////////////////////////////////
    // Payload as it sits in a bank queue. The address is implied by the queue.
    typedef struct packed {
        logic [IDX_W-1:0]  idx;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
        logic [DATA_W-1:0] data;
        logic              is_write;
    } mem_req_t;

    typedef struct packed {
        logic [BG_W-1:0] bg;
        logic [BA_W-1:0] ba;
        mem_req_t        req;
    } req_in_t;

    typedef struct packed {
        logic [BG_W-1:0] bg;
        logic [BA_W-1:0] ba;
        mem_req_t        req;
    } mem_cmd_t;

    // Both scheduling levels choose among four requesters.
    // Search starts just after the last winner; the last winner itself comes last.
    function automatic logic [1:0] rr_next(input logic [3:0] req, input logic [1:0] last);
        logic [1:0] cand;
        rr_next = last;
        for (int k = 4; k >= 1; k--) begin
            cand = last + 2'(k);
            if (req[cand]) begin
                rr_next = cand;
            end
        end
    endfunction

endpackage

`default_nettype wire

//--- src/bank_queue.sv
`default_nettype none

module bank_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                push_i,
    input  sched_pkg::mem_req_t push_data_i,
    input  logic                pop_i,
    output logic                valid_o,
    output sched_pkg::mem_req_t head_o,
    output logic                overflow_o
);
    import sched_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    mem_req_t         entries_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        ptr_inc = (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (count_q == CNT_W'(QUEUE_DEPTH));
    assign valid_o = (count_q != '0);
    assign head_o  = entries_q[rd_ptr_q];
    assign do_push = push_i && !full;  // A push into a full queue is lost.
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_ptr_q   <= '0;
            wr_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= push_i && full;
            if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/group_sched.sv
`default_nettype none

module group_sched (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             sched_en_i,
    input  logic [sched_pkg::NUM_GROUPS-1:0] group_req_i,
    input  logic [sched_pkg::NUM_GROUPS-1:0] group_done_i,
    output logic [sched_pkg::NUM_GROUPS-1:0] group_start_o,
    output logic [sched_pkg::BG_W-1:0]       group_sel_o
);
    import sched_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_BUSY
    } state_t;

    state_t          state_q;
    logic [BG_W-1:0] last_q;  // Group served most recently.
    logic [BG_W-1:0] pick;

    // Switching groups on every start suits DDR4, where a different
    // bank group can be addressed sooner than the same one.
    assign pick = rr_next(group_req_i, last_q);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q       <= S_IDLE;
            last_q        <= BG_W'(NUM_GROUPS - 1);
            group_start_o <= '0;
            group_sel_o   <= '0;
        end else begin
            group_start_o <= '0;
            case (state_q)
                S_IDLE: begin
                    if (sched_en_i && |group_req_i) begin
                        group_start_o[pick] <= 1'b1;
                        group_sel_o         <= pick;  // Held until that group is done.
                        last_q              <= pick;
                        state_q             <= S_BUSY;
                    end
                end
                S_BUSY: begin
                    if (group_done_i[group_sel_o]) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/bank_group_sched.sv
`default_nettype none

module bank_group_sched (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  start_i,
    input  logic [sched_pkg::BANKS_PER_GROUP-1:0] bank_valid_i,
    output logic [sched_pkg::BANKS_PER_GROUP-1:0] pop_o,
    output logic [sched_pkg::BA_W-1:0]            bank_sel_o,
    output logic                                  grant_o,
    output logic                                  done_o,
    output logic                                  group_req_o
);
    import sched_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_ISSUED
    } state_t;

    state_t          state_q;
    logic [BA_W-1:0] last_q;
    logic [BA_W-1:0] pick;

    assign pick        = rr_next(bank_valid_i, last_q);
    assign group_req_o = |bank_valid_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= S_IDLE;
            last_q     <= BA_W'(BANKS_PER_GROUP - 1);
            pop_o      <= '0;
            bank_sel_o <= '0;
            grant_o    <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            pop_o   <= '0;
            grant_o <= 1'b0;
            done_o  <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q     <= S_ISSUED;
                        // The group only starts us while a bank is valid,
                        // and only this block pops its banks.
                        grant_o     <= 1'b1;
                        pop_o[pick] <= 1'b1;
                        bank_sel_o  <= pick;
                        last_q      <= pick;
                    end
                end
                S_ISSUED: begin
                    done_o  <= 1'b1;  // Hands the slot back to the group scheduler.
                    state_q <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/cmd_mux.sv
`default_nettype none

module cmd_mux (
    input  logic                                         clk,
    input  logic                                         rst_i,
    input  sched_pkg::mem_req_t [sched_pkg::NUM_BANKS-1:0] bank_head_i,
    input  logic [sched_pkg::NUM_GROUPS-1:0]             grant_i,
    input  logic [sched_pkg::NUM_GROUPS*sched_pkg::BA_W-1:0] bank_sel_i,
    input  logic [sched_pkg::BG_W-1:0]                   group_sel_i,
    output logic                                         cmd_valid_o,
    output sched_pkg::mem_cmd_t                          cmd_o
);
    import sched_pkg::*;

    logic [BA_W-1:0]      ba_sel;
    logic [BG_W+BA_W-1:0] bank_idx;

    // Only the active group can grant, so its bank select is the one to use.
    assign ba_sel   = bank_sel_i[group_sel_i*BA_W +: BA_W];
    assign bank_idx = {group_sel_i, ba_sel};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= |grant_i;
        end
    end

    // The pop lands on this same edge, so the head is still the granted entry.
    always_ff @(posedge clk) begin
        if (|grant_i) begin
            cmd_o.bg  <= group_sel_i;
            cmd_o.ba  <= ba_sel;
            cmd_o.req <= bank_head_i[bank_idx];
        end
    end

endmodule

`default_nettype wire

//--- src/cmd_arbiter.sv
`default_nettype none

module cmd_arbiter (
    input  logic                                         clk,
    input  logic                                         rst_i,
    input  logic                                         sched_en_i,
    input  logic [sched_pkg::NUM_BANKS-1:0]              bank_valid_i,
    input  sched_pkg::mem_req_t [sched_pkg::NUM_BANKS-1:0] bank_head_i,
    output logic [sched_pkg::NUM_BANKS-1:0]              bank_pop_o,
    output logic                                         cmd_valid_o,
    output sched_pkg::mem_cmd_t                          cmd_o
);
    import sched_pkg::*;

    logic [NUM_GROUPS-1:0]      group_req;
    logic [NUM_GROUPS-1:0]      group_done;
    logic [NUM_GROUPS-1:0]      group_start;
    logic [NUM_GROUPS-1:0]      grant;
    logic [NUM_GROUPS*BA_W-1:0] bank_sel;
    logic [BG_W-1:0]            group_sel;

    group_sched u_group_sched (
        .clk           (clk),
        .rst_i         (rst_i),
        .sched_en_i    (sched_en_i),
        .group_req_i   (group_req),
        .group_done_i  (group_done),
        .group_start_o (group_start),
        .group_sel_o   (group_sel)
    );

    //////////////////////////////////////////////////////////////////////
    // One bank scheduler per group, each owning a slice of the banks.
    for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
        bank_group_sched u_bank_group_sched (
            .clk          (clk),
            .rst_i        (rst_i),
            .start_i      (group_start[g]),
            .bank_valid_i (bank_valid_i[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .pop_o        (bank_pop_o[g*BANKS_PER_GROUP +: BANKS_PER_GROUP]),
            .bank_sel_o   (bank_sel[g*BA_W +: BA_W]),
            .grant_o      (grant[g]),
            .done_o       (group_done[g]),
            .group_req_o  (group_req[g])
        );
    end

    cmd_mux u_cmd_mux (
        .clk         (clk),
        .rst_i       (rst_i),
        .bank_head_i (bank_head_i),
        .grant_i     (grant),
        .bank_sel_i  (bank_sel),
        .group_sel_i (group_sel),
        .cmd_valid_o (cmd_valid_o),
        .cmd_o       (cmd_o)
    );

endmodule

`default_nettype wire

//--- src/mem_sched_top.sv
`default_nettype none

module mem_sched_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                req_valid_i,
    input  sched_pkg::req_in_t  req_i,
    input  logic                sched_en_i,
    output logic                cmd_valid_o,
    output sched_pkg::mem_cmd_t cmd_o,
    output logic                overflow_o
);
    import sched_pkg::*;

    logic [NUM_BANKS-1:0]     bank_push;
    logic [NUM_BANKS-1:0]     bank_pop;
    logic [NUM_BANKS-1:0]     bank_valid;
    logic [NUM_BANKS-1:0]     bank_overflow;
    mem_req_t [NUM_BANKS-1:0] bank_head;
    logic [BG_W+BA_W-1:0]     req_bank;

    // Flat bank number, group in the upper bits.
    assign req_bank   = {req_i.bg, req_i.ba};
    assign overflow_o = |bank_overflow;

    //////////////////////////////////////////////////////////////////////
    // Bank queues.
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign bank_push[b] = req_valid_i && (req_bank == (BG_W + BA_W)'(b));

        bank_queue #(
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) u_bank_queue (
            .clk         (clk),
            .rst_i       (rst_i),
            .push_i      (bank_push[b]),
            .push_data_i (req_i.req),
            .pop_i       (bank_pop[b]),
            .valid_o     (bank_valid[b]),
            .head_o      (bank_head[b]),
            .overflow_o  (bank_overflow[b])
        );
    end

    cmd_arbiter u_cmd_arbiter (
        .clk          (clk),
        .rst_i        (rst_i),
        .sched_en_i   (sched_en_i),
        .bank_valid_i (bank_valid),
        .bank_head_i  (bank_head),
        .bank_pop_o   (bank_pop),
        .cmd_valid_o  (cmd_valid_o),
        .cmd_o        (cmd_o)
    );

endmodule

`default_nettype wire

//--- verification/tb_mem_sched.sv
`default_nettype none

module tb_mem_sched;
    import sched_pkg::*;

    localparam int QUEUE_DEPTH  = 4;
    localparam int CLK_HALF     = 2;
    localparam int RESET_CYCLES = 8;
    localparam int SEED         = 32'hed69_98e6;

    typedef struct packed {
        req_in_t    req;
        logic       push;
        logic       en;     // Level of sched_en_i for this cycle.
        logic       drop;   // Lands on a full queue.
        logic       drain;  // Wait here until every pending command has issued.
        logic [7:0] seq;    // Position in the command stream.
    } step_t;

    logic     clk;
    logic     rst_i;
    logic     req_valid_i;
    req_in_t  req_i;
    logic     sched_en_i;
    logic     cmd_valid_o;
    mem_cmd_t cmd_o;
    logic     overflow_o;

    step_t steps[$];
    step_t sb[NUM_BANKS][$];  // Expected requests, one queue per bank.
    int    pending;
    int    issued;
    int    overflows;
    int    drops_expected;
    int    since_en;
    bit    table_built;

    mem_sched_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .sched_en_i  (sched_en_i),
        .cmd_valid_o (cmd_valid_o),
        .cmd_o       (cmd_o),
        .overflow_o  (overflow_o)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "Check %s failed.", name);
        end
    endtask

    function automatic void add_step(input int bg, input int ba, input bit push, input bit en,
                                     input bit drop, input bit drain, input int seq);
        step_t s;
        s                  = '0;
        s.req.bg           = BG_W'(bg);
        s.req.ba           = BA_W'(ba);
        s.req.req.idx      = IDX_W'(steps.size());  // Unique tag per row.
        s.req.req.row      = ROW_W'($urandom);
        s.req.req.col      = COL_W'($urandom);
        s.req.req.data     = DATA_W'($urandom);
        s.req.req.is_write = 1'($urandom);
        s.push             = push;
        s.en               = en;
        s.drop             = drop;
        s.drain            = drain;
        s.seq              = 8'(seq);
        steps.push_back(s);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus table. Every phase loads with scheduling off, so the
    // round-robin order below is fixed.
    function automatic void build_table();
        repeat (8) add_step(0, 0, 0, 1, 0, 0, 0);  // Quiet after reset.
        // Two groups loaded, commands alternate between groups 0 and 2.
        add_step(0, 0, 1, 0, 0, 0, 0);
        add_step(0, 0, 1, 0, 0, 0, 2);
        add_step(2, 1, 1, 0, 0, 0, 1);
        add_step(2, 1, 1, 0, 0, 0, 3);
        add_step(0, 0, 0, 1, 0, 1, 0);
        // Group 1 loaded in reverse, still served as banks 0, 1, 2, 3.
        add_step(1, 3, 1, 0, 0, 0, 7);
        add_step(1, 2, 1, 0, 0, 0, 6);
        add_step(1, 1, 1, 0, 0, 0, 5);
        add_step(1, 0, 1, 0, 0, 0, 4);
        add_step(0, 0, 0, 1, 0, 1, 0);
        // One bank pushed past its depth; the last push is dropped.
        for (int k = 0; k <= QUEUE_DEPTH; k++) begin
            add_step(3, 2, 1, 0, k == QUEUE_DEPTH, 0, 8 + k);
        end
        repeat (3) add_step(0, 0, 0, 0, 0, 0, 0);
        add_step(0, 0, 0, 1, 0, 1, 0);
        repeat (6) add_step(0, 0, 0, 1, 0, 0, 0);
    endfunction

    task automatic score_command();
        int    b;
        step_t exp;
        b = int'({cmd_o.bg, cmd_o.ba});
        if (sb[b].size() == 0) begin
            $display("A command for bank %0d issued with no request pending there.", b);
            $display("Simulation finished: FAIL");
            $fatal(1, "Unexpected command.");
        end else begin
            exp = sb[b].pop_front();
            pending--;
            check("command fields", 64'(exp.req), 64'(cmd_o));
            check("issue order", 64'(exp.seq), 64'(issued));
            check("sched_en gate", 64'(1), 64'(since_en <= 3));
            issued++;
        end
    endtask

    // Outputs are sampled on the falling edge, away from the drive edge.
    always @(negedge clk) begin
        if (rst_i) begin
            since_en = 0;
        end else begin
            since_en = sched_en_i ? 0 : since_en + 1;  // Cycles since scheduling was on.
            if (overflow_o) overflows++;
            if (cmd_valid_o) score_command();
        end
    end

    initial begin
        wait (table_built);
        repeat (steps.size() * 3 + 100) @(posedge clk);
        $display("Watchdog expired: the scheduler did not drain in time.");
        $display("Simulation finished: FAIL");
        $fatal(1, "Timeout.");
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence.
    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        sched_en_i  = 1'b0;
        void'($urandom(SEED));
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;

        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            req_valid_i <= steps[i].push;
            req_i       <= steps[i].req;
            sched_en_i  <= steps[i].en;
            if (steps[i].push && steps[i].drop) begin
                drops_expected++;
            end else if (steps[i].push) begin
                sb[{steps[i].req.bg, steps[i].req.ba}].push_back(steps[i]);
                pending++;
            end
            if (steps[i].drain) begin
                while (pending > 0) @(posedge clk);
            end
        end

        check("overflow pulses", 64'(drops_expected), 64'(overflows));
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
src/sched_pkg.sv
src/bank_queue.sv
src/group_sched.sv
src/bank_group_sched.sv
src/cmd_mux.sv
src/cmd_arbiter.sv
src/mem_sched_top.sv
verification/tb_mem_sched.sv

//--- Makefile
# Verilator build and run for the memory command scheduler.

VERILATOR ?= verilator
TOP       ?= tb_mem_sched
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
